/* source/stt8_pkg.sv */
/*
 * Shared constants and types for the tile and sprite video path.
 * Timing is fixed at 640x480 with 800x525 total clocks and one pixel per clock.
 * Sprites are 8x8 texels, scaled by four, so each one fills a single 32-pixel tile.
 * An ID of 15 marks an unused entity slot. Sprite 15 is blank for the same reason.
 */
`default_nettype none

package stt8_pkg;

    localparam logic [9:0] H_ACTIVE = 10'd640;    // Visible pixels per line
    localparam logic [9:0] H_FRONT  = 10'd16;     // Front porch
    localparam logic [9:0] H_SYNC   = 10'd96;     // Sync pulse, low for x 656..751
    localparam logic [9:0] H_TOTAL  = 10'd800;    // Clocks per line

    localparam logic [9:0] V_ACTIVE = 10'd480;    // Visible lines
    localparam logic [9:0] V_FRONT  = 10'd10;     // Front porch lines
    localparam logic [9:0] V_SYNC   = 10'd2;      // Sync pulse, low for y 490..491
    localparam logic [9:0] V_TOTAL  = 10'd525;    // Lines per frame

    localparam int N_ENTITIES  = 4;               // Entity slots, slot 0 has top priority
    localparam int TILE_SHIFT  = 5;               // 32-pixel tiles
    localparam int SCALE_SHIFT = 2;               // Each texel covers 4x4 pixels

    localparam logic [3:0] ENTITY_UNUSED = 4'd15;

    // Orient: 0 none, 1 mirror x, 2 mirror y, 3 rotate 180
    typedef struct packed {
        logic [3:0] id;
        logic [1:0] orient;
        logic [7:0] tile;                         // Row in [7:4], column in [3:0]
    } entity_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;                       // Inside the 640x480 area
        logic       hsync;                        // Active low
        logic       vsync;                        // Active low
    } timing_t;

    typedef struct packed {
        timing_t    t;
        logic       hit;                          // Some entity covers this pixel
        logic [3:0] id;
        logic [1:0] orient;
        logic [2:0] sx;                           // Texel column before orientation
        logic [2:0] sy;                           // Texel row before orientation
    } locate_t;

    typedef struct packed {
        timing_t t;
        logic    on;                              // Lit sprite texel
    } pixel_t;

    // Sprite bitmaps, one byte per texel row, bit 7 is the leftmost texel
    localparam logic [7:0] SPRITE_ROM [16][8] = '{
        '{8'hFE, 8'h80, 8'h80, 8'hFC, 8'h80, 8'h80, 8'h80, 8'h00},   // Letter F
        '{8'h18, 8'h3C, 8'h7E, 8'hFF, 8'hDB, 8'h18, 8'h24, 8'h42},   // Ship
        '{8'h66, 8'hFF, 8'hFF, 8'hFF, 8'h7E, 8'h3C, 8'h18, 8'h00},   // Heart
        '{8'h08, 8'h0C, 8'hFE, 8'hFF, 8'hFE, 8'h0C, 8'h08, 8'h00},   // Arrow right
        '{8'h3C, 8'h42, 8'hA5, 8'h81, 8'hA5, 8'h99, 8'h42, 8'h3C},   // Face
        '{8'hAA, 8'h55, 8'hAA, 8'h55, 8'hAA, 8'h55, 8'hAA, 8'h55},   // Checker
        '{8'hFF, 8'h81, 8'h81, 8'h81, 8'h81, 8'h81, 8'h81, 8'hFF},   // Box
        '{8'h80, 8'h40, 8'h20, 8'h10, 8'h08, 8'h04, 8'h02, 8'h01},   // Diagonal
        '{8'hC0, 8'hC0, 8'hC0, 8'hC0, 8'hC0, 8'hC0, 8'hFF, 8'hFF},   // Letter L
        '{8'h70, 8'h88, 8'h88, 8'h7F, 8'h05, 8'h05, 8'h00, 8'h00},   // Key
        '{8'h18, 8'h18, 8'h18, 8'hFF, 8'hFF, 8'h18, 8'h18, 8'h18},   // Cross
        '{8'h10, 8'h38, 8'h7C, 8'hFE, 8'h38, 8'h7C, 8'hFE, 8'h10},   // Tree
        '{8'hFF, 8'h88, 8'h88, 8'hFF, 8'h22, 8'h22, 8'hFF, 8'h00},   // Bricks
        '{8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF},   // Solid
        '{8'h00, 8'h00, 8'h18, 8'h3C, 8'h3C, 8'h18, 8'h00, 8'h00},   // Dot
        '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}    // Unused slot
    };

endpackage

`default_nettype wire

/* source/vga_timing.sv */
/*
 * Pixel and line counters for 640x480 VGA timing, one pixel per clock.
 * Flags are registered together with the counters, so every field of the
 * output describes the same pixel. After reset the output shows pixel (0,0).
 */
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import stt8_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    output timing_t timing
);

    logic       x_wrap;                           // Last clock of a line
    logic [9:0] x_next;
    logic [9:0] y_next;

    assign x_wrap = (timing.x == H_TOTAL - 10'd1);
    assign x_next = x_wrap ? 10'd0 : timing.x + 10'd1;

    always_comb begin
        y_next = timing.y;                        // Hold within a line
        if (x_wrap) begin
            y_next = (timing.y == V_TOTAL - 10'd1) ? 10'd0 : timing.y + 10'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timing.x      <= 10'd0;
            timing.y      <= 10'd0;
            timing.active <= 1'b1;                // Pixel (0,0) is visible
            timing.hsync  <= 1'b1;
            timing.vsync  <= 1'b1;
        end else begin
            timing.x      <= x_next;
            timing.y      <= y_next;
            timing.active <= (x_next < H_ACTIVE) && (y_next < V_ACTIVE);
            // Sync pulses sit right after the front porch
            timing.hsync  <= !((x_next >= H_ACTIVE + H_FRONT) &&
                               (x_next <  H_ACTIVE + H_FRONT + H_SYNC));
            timing.vsync  <= !((y_next >= V_ACTIVE + V_FRONT) &&
                               (y_next <  V_ACTIVE + V_FRONT + V_SYNC));
        end
    end

    // Line counter never runs past the last clock of a line
    a_x_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        timing.x < H_TOTAL
    ) else $error("x counter out of range: %0d", timing.x);

endmodule

`default_nettype wire

/* source/entity_locator.sv */
/*
 * First pipeline stage. Finds the entity that sits on the current tile.
 * Tiles exist only for x below 512 inside the visible area, 16 columns by
 * 15 rows. Slots with ID 15 are skipped and the lowest matching slot wins.
 * Entity words are sampled every clock and should be stable within a frame.
 */
`timescale 1ns/1ps
`default_nettype none

module entity_locator
    import stt8_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire timing_t                  timing_in,
    input  wire entity_t [N_ENTITIES-1:0] entities,
    output locate_t                       loc
);

    logic [3:0] col;                              // Tile column 0..15
    logic [3:0] row;                              // Tile row 0..14
    logic       tile_valid;
    logic       hit_d;
    entity_t    sel_d;                            // Winning entity word

    assign col        = timing_in.x[TILE_SHIFT +: 4];
    assign row        = timing_in.y[TILE_SHIFT +: 4];
    assign tile_valid = timing_in.active && !timing_in.x[TILE_SHIFT + 4];   // x < 512

    // Walk from the top slot down so the lowest match is written last
    always_comb begin
        hit_d = 1'b0;
        sel_d = '0;
        for (int i = N_ENTITIES - 1; i >= 0; i--) begin
            if (tile_valid && (entities[i].id != ENTITY_UNUSED) &&
                (entities[i].tile == {row, col})) begin
                hit_d = 1'b1;
                sel_d = entities[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        loc.t      <= timing_in;
        loc.hit    <= hit_d;
        loc.id     <= sel_d.id;
        loc.orient <= sel_d.orient;
        loc.sx     <= timing_in.x[SCALE_SHIFT +: 3];   // Texel inside the tile
        loc.sy     <= timing_in.y[SCALE_SHIFT +: 3];
        if (!rst_n) begin
            loc.hit      <= 1'b0;
            loc.t.active <= 1'b0;
            loc.t.hsync  <= 1'b1;                 // Syncs idle high
            loc.t.vsync  <= 1'b1;
        end
    end

    // A hit must always name a real sprite
    a_hit_not_unused: assert property (
        @(posedge clk) disable iff (!rst_n)
        loc.hit |-> (loc.id != ENTITY_UNUSED)
    ) else $error("hit reported with unused entity ID");

endmodule

`default_nettype wire

/* source/sprite_rom.sv */
/*
 * Second pipeline stage. Applies the entity orientation to the texel
 * coordinates and reads one bit from the sprite bitmaps.
 * Orient bit 0 mirrors x and bit 1 mirrors y, so code 3 is a 180 degree turn.
 * Timing fields pass through unchanged, one clock later.
 */
`timescale 1ns/1ps
`default_nettype none

module sprite_rom
    import stt8_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire locate_t loc,
    output pixel_t  pix
);

    logic [2:0] tex_x;                            // Texel column after orientation
    logic [2:0] tex_y;                            // Texel row after orientation
    logic [7:0] row_bits;
    logic       texel;

    assign tex_x = loc.sx ^ {3{loc.orient[0]}};   // Mirror x for orient 1 and 3
    assign tex_y = loc.sy ^ {3{loc.orient[1]}};   // Mirror y for orient 2 and 3

    assign row_bits = SPRITE_ROM[loc.id][tex_y];
    assign texel    = row_bits[3'd7 - tex_x];     // Bit 7 is the leftmost texel

    always_ff @(posedge clk) begin
        pix.t  <= loc.t;
        pix.on <= texel && loc.hit;               // Empty tiles stay dark
        if (!rst_n) begin
            pix.on       <= 1'b0;
            pix.t.active <= 1'b0;
            pix.t.hsync  <= 1'b1;
            pix.t.vsync  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/pixel_output.sv */
/*
 * Last pipeline stage. Blanks the colour outside the visible area and
 * expands the monochrome pixel to 2 bits per channel.
 * Syncs get the same register so they stay aligned with the colour.
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_output
    import stt8_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire pixel_t pix,
    output logic       hsync,
    output logic       vsync,
    output logic [1:0] r,
    output logic [1:0] g,
    output logic [1:0] b
);

    logic lit;

    assign lit = pix.on && pix.t.active;          // Blank outside 640x480

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            r     <= 2'd0;
            g     <= 2'd0;
            b     <= 2'd0;
        end else begin
            hsync <= pix.t.hsync;
            vsync <= pix.t.vsync;
            r     <= {2{lit}};                    // White or black only
            g     <= {2{lit}};
            b     <= {2{lit}};
        end
    end

    // Nothing may light up during blanking
    a_blank_dark: assert property (
        @(posedge clk) disable iff (!rst_n)
        !pix.t.active |=> ((r == 2'd0) && (g == 2'd0) && (b == 2'd0))
    ) else $error("colour driven during blanking");

endmodule

`default_nettype wire

/* source/stt8_top.sv */
/*
 * Tile and sprite video generator, 640x480 VGA with one pixel per clock.
 * Four entity slots place scaled 8x8 sprites on a 16x15 grid of 32-pixel
 * tiles, slot 0 in front. Colour and syncs lag the timing counters by
 * 3 clocks. Entity words should only change during vertical blanking.
 */
`timescale 1ns/1ps
`default_nettype none

module stt8_top
    import stt8_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire entity_t [N_ENTITIES-1:0] entities,   // Slot 0 has priority
    output logic                          hsync,
    output logic                          vsync,
    output logic [1:0]                    r,
    output logic [1:0]                    g,
    output logic [1:0]                    b
);

    timing_t timing;                              // Counter stage
    locate_t loc;                                 // After tile match
    pixel_t  pix;                                 // After bitmap lookup

    vga_timing u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .timing (timing)
    );

    entity_locator u_locator (
        .clk       (clk),
        .rst_n     (rst_n),
        .timing_in (timing),
        .entities  (entities),
        .loc       (loc)
    );

    sprite_rom u_sprite (
        .clk   (clk),
        .rst_n (rst_n),
        .loc   (loc),
        .pix   (pix)
    );

    pixel_output u_output (
        .clk   (clk),
        .rst_n (rst_n),
        .pix   (pix),
        .hsync (hsync),
        .vsync (vsync),
        .r     (r),
        .g     (g),
        .b     (b)
    );

endmodule

`default_nettype wire

/* tb/tb_stt8.sv */
/*
 * Testbench for the tile and sprite video generator.
 * Keeps its own output pixel counter, which starts 3 clocks after reset release,
 * and checks syncs and blanking on every clock. Each table row loads the entity
 * slots during vertical blanking and then probes one pixel.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_stt8
    import stt8_pkg::*;
();

    localparam int ROWS       = 16;
    localparam int FRAME_CLKS = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int TILE_LIMIT = 16 << TILE_SHIFT;    // No tiles from x 512 on
    localparam int HS_FIRST   = 656;                 // Horizontal sync low from here
    localparam int HS_LAST    = 751;
    localparam int VS_FIRST   = 490;                 // Vertical sync low on these lines
    localparam int VS_LAST    = 491;
    localparam entity_t NONE  = '{ENTITY_UNUSED, 2'd0, 8'h00};

    typedef struct packed {
        entity_t [N_ENTITIES-1:0] ents;
        logic [9:0]               x;                 // Probe pixel
        logic [9:0]               y;
        logic [1:0]               colour;            // Expected level on r, g and b
    } vector_t;

    logic                     clk;
    logic                     rst_n;
    entity_t [N_ENTITIES-1:0] entities;
    logic                     hsync;
    logic                     vsync;
    logic [1:0]               r;
    logic [1:0]               g;
    logic [1:0]               b;

    int      px;                                     // Pixel now on the outputs
    int      py;
    int      start_cnt;
    logic    px_valid;
    logic    exp_hs;
    logic    exp_vs;
    int      errors;
    int      checks;
    int      timeouts;
    int      n_rows;
    vector_t vectors [ROWS];

    stt8_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .entities (entities),
        .hsync    (hsync),
        .vsync    (vsync),
        .r        (r),
        .g        (g),
        .b        (b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // First pixel leaves the pipeline on the third edge after release
    always @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= 0;
            px_valid  <= 1'b0;
            px        <= 0;
            py        <= 0;
        end else if (!px_valid) begin
            if (start_cnt == 2) px_valid <= 1'b1;
            else start_cnt <= start_cnt + 1;
        end else if (px == int'(H_TOTAL) - 1) begin
            px <= 0;
            py <= (py == int'(V_TOTAL) - 1) ? 0 : py + 1;   // Frame wrap
        end else begin
            px <= px + 1;
        end
    end

    task automatic report(input string name, input int exp_v, input int got_v);
        errors++;
        $display("[ERROR] %0t ns %s: expected %0d, got %0d", $time, name, exp_v, got_v);
    endtask

    // Sync and blanking rules hold on every output pixel
    always @(negedge clk) begin
        if (px_valid) begin
            checks++;
            exp_hs = !(px >= HS_FIRST && px <= HS_LAST);
            exp_vs = !(py >= VS_FIRST && py <= VS_LAST);
            if (hsync !== exp_hs) report($sformatf("hsync at (%0d,%0d)", px, py), exp_hs, hsync);
            if (vsync !== exp_vs) report($sformatf("vsync at (%0d,%0d)", px, py), exp_vs, vsync);
            if ((px >= TILE_LIMIT || py >= int'(V_ACTIVE)) && ({r, g, b} !== 6'd0))
                report($sformatf("rgb at (%0d,%0d)", px, py), 0, {r, g, b});
        end
    end

    // Lowest slot on the tile wins and its texel is read after mirroring
    function automatic logic [1:0] expected_colour(input entity_t [N_ENTITIES-1:0] ents,
                                                   input int x, input int y);
        int         slot;
        int         tx;
        int         ty;
        logic [7:0] bits;
        slot = -1;
        if (x < TILE_LIMIT && y < int'(V_ACTIVE)) begin
            for (int i = 0; i < N_ENTITIES; i++) begin
                if (slot < 0 && ents[i].id != ENTITY_UNUSED &&
                    int'(ents[i].tile[7:4]) == (y >> TILE_SHIFT) &&
                    int'(ents[i].tile[3:0]) == (x >> TILE_SHIFT)) slot = i;
            end
        end
        if (slot < 0) return 2'd0;
        tx = (x >> SCALE_SHIFT) % 8;
        ty = (y >> SCALE_SHIFT) % 8;
        if (ents[slot].orient == 2'd1 || ents[slot].orient == 2'd3) tx = 7 - tx;
        if (ents[slot].orient == 2'd2 || ents[slot].orient == 2'd3) ty = 7 - ty;
        bits = SPRITE_ROM[ents[slot].id][ty];
        return bits[7 - tx] ? 2'd3 : 2'd0;
    endfunction

    function automatic entity_t make_entity(input int id, input int orient, input int tile);
        return '{id[3:0], orient[1:0], tile[7:0]};
    endfunction

    task automatic add_row(input entity_t e0, e1, e2, e3, input int x, y);
        entity_t [N_ENTITIES-1:0] ents;
        ents = {e3, e2, e1, e0};
        vectors[n_rows] = '{ents, x[9:0], y[9:0], expected_colour(ents, x, y)};
        n_rows++;
    endtask

    task automatic wait_pixel(input int x, input int y);
        int n;
        n = 0;
        @(negedge clk);
        while (!(px_valid && px == x && py == y) && n < 2 * FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (n >= 2 * FRAME_CLKS) begin
            $display("Timeout: pixel (%0d,%0d) never reached the outputs", x, y);
            timeouts++;
        end
    endtask

    initial begin
        int         i;
        logic [1:0] want;
        rst_n    = 1'b0;
        entities = {N_ENTITIES{NONE}};
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        n_rows   = 0;
        // Tile row 3, column 5 spans x 160..191 and y 96..127
        add_row(make_entity(0, 0, 'h35), NONE, NONE, NONE, 161, 98);    // Letter F at texel (0,0)
        add_row(make_entity(0, 0, 'h35), NONE, NONE, NONE, 173, 110);   // Texel (3,3)
        add_row(make_entity(0, 0, 'h35), NONE, NONE, NONE, 193, 98);    // Tile to the right
        add_row(make_entity(0, 0, 'h35), NONE, NONE, NONE, 161, 130);   // Tile below
        for (i = 0; i < 4; i++)
            add_row(make_entity(8, i, 'h35), NONE, NONE, NONE, 161, 98);  // Letter L per orient
        add_row(make_entity(8, 2, 'h35), NONE, NONE, NONE, 189, 98);    // Texel (7,0)
        add_row(make_entity(0, 0, 'h35), make_entity(13, 0, 'h35), NONE, NONE, 189, 98);
        add_row(make_entity(13, 0, 'h35), NONE, make_entity(0, 0, 'h35), NONE, 189, 98);
        add_row(make_entity(15, 0, 'h35), make_entity(13, 0, 'h35), NONE, NONE, 189, 98);
        add_row(make_entity(13, 0, 'hEF), NONE, NONE, NONE, 511, 479);  // Last tile
        add_row(make_entity(13, 0, 'h00), NONE, NONE, NONE, 520, 5);    // Beyond the grid
        add_row(make_entity(13, 0, 'h00), NONE, NONE, NONE, 5, 5);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if (hsync !== 1'b1) report("hsync after reset", 1, hsync);
        if (vsync !== 1'b1) report("vsync after reset", 1, vsync);
        if ({r, g, b} !== 6'd0) report("rgb after reset", 0, {r, g, b});

        for (i = 0; i < n_rows && timeouts == 0; i++) begin
            wait_pixel(0, int'(V_ACTIVE) + 5);        // Inside vertical blanking
            @(posedge clk);
            entities <= vectors[i].ents;
            wait_pixel(int'(vectors[i].x), int'(vectors[i].y));
            if (timeouts == 0) begin
                want = vectors[i].colour;
                checks++;
                if (r !== want) report($sformatf("r (row %0d)", i), want, r);
                if (g !== want) report($sformatf("g (row %0d)", i), want, g);
                if (b !== want) report($sformatf("b (row %0d)", i), want, b);
            end
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/stt8_pkg.sv
source/vga_timing.sv
source/entity_locator.sv
source/sprite_rom.sv
source/pixel_output.sv
source/stt8_top.sv
tb/tb_stt8.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stt8 -f sources.f -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -Fqx "All tests passed"; then
    exit 0
fi
exit 1
